/* Makefile */
# Verilator build and run for the OSD overlay testbench

VERILATOR ?= verilator
TOP       ?= tb_osd_overlay
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
osd_bus_pkg.sv
osd_video_pkg.sv
osd_bus_port.sv
osd_raster.sv
osd_ram.sv
osd_pixel_out.sv
osd_overlay_top.sv
tb_osd_overlay.sv

/* osd_bus_pkg.sv */
/*
  CPU bus definitions for the OSD overlay: request struct, address map
  and the bitmap RAM geometry seen from the bus side.
  Import into any block that decodes or carries CPU accesses.
*/
package osd_bus_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_word_t;
  // all zero means read
  typedef logic [3:0]  bus_strb_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_word_t wdata;
    bus_strb_t wstrb;
  } cpu_req_t;

  //////////////////////////////////////////////////////////////////////
  // address map

  // top nibble selects the bitmap RAM
  localparam logic [3:0] RAM_REGION = 4'h1;

  // single control register, bit 0 enables the overlay
  localparam bus_addr_t  CTRL_ADDR  = 32'h3000_0000;

  //////////////////////////////////////////////////////////////////////
  // bitmap RAM

  localparam int RAM_WORDS = 1024;

  // word index, byte address bits 11..2
  typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t;

endpackage

/* osd_bus_port.sv */
/*
  CPU side of the overlay. Decodes valid/ready requests into the control
  register, the shared bitmap RAM or unmapped space, and answers each one
  with a single-cycle ready pulse carrying the read data.
*/
`timescale 1ns/1ns

module osd_bus_port (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_cpu_valid,
  input  osd_bus_pkg::cpu_req_t  i_cpu_req,
  output logic                   o_cpu_ready,
  output osd_bus_pkg::bus_word_t o_cpu_rdata,
  output logic                   o_ram_req,
  output osd_bus_pkg::ram_addr_t o_ram_addr,
  output osd_bus_pkg::bus_word_t o_ram_wdata,
  output osd_bus_pkg::bus_strb_t o_ram_wstrb,
  input  logic                   i_cpu_grant,
  input  osd_bus_pkg::bus_word_t i_ram_rdata,
  output logic                   o_osd_enable
);

  import osd_bus_pkg::*;

  logic      is_ram;
  logic      is_ctrl;
  logic      reg_start;
  logic      ctrl_q;
  logic      ram_done_q;
  bus_word_t rdata_q;

  // address decode
  assign is_ram   = i_cpu_req.addr[31:28] == RAM_REGION;
  assign is_ctrl  = i_cpu_req.addr == CTRL_ADDR;

  // control and unmapped accesses finish in one cycle
  assign reg_start = i_cpu_valid && !o_cpu_ready && !is_ram;

  // held until the RAM finds a cycle free of video fetches
  assign o_ram_req   = i_cpu_valid && is_ram && !o_cpu_ready;
  assign o_ram_addr  = i_cpu_req.addr[11:2];
  assign o_ram_wdata = i_cpu_req.wdata;
  assign o_ram_wstrb = i_cpu_req.wstrb;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cpu_ready <= 1'b0;
      ram_done_q  <= 1'b0;
      ctrl_q      <= 1'b0;
    end else begin
      o_cpu_ready <= reg_start || i_cpu_grant;
      ram_done_q  <= i_cpu_grant;
      if (reg_start && is_ctrl && i_cpu_req.wstrb[0]) begin
        ctrl_q <= i_cpu_req.wdata[0];
      end
    end
  end

  // unmapped reads give zero
  always_ff @(posedge clk) begin
    if (reg_start && is_ctrl) begin
      rdata_q <= bus_word_t'(ctrl_q);
    end else begin
      rdata_q <= '0;
    end
  end

  // RAM word arrives registered, same cycle as ready
  assign o_cpu_rdata  = ram_done_q ? i_ram_rdata : rdata_q;
  assign o_osd_enable = ctrl_q;

  //////////////////////////////////////////////////////////////////////
  // protocol checks

  // the master keeps valid up to and including the ready cycle
  a_ready_with_valid: assert property (
    @(posedge clk) disable iff (rst) o_cpu_ready |-> i_cpu_valid
  );

  // one ready per request, never back to back
  a_ready_pulse: assert property (
    @(posedge clk) disable iff (rst) o_cpu_ready |=> !o_cpu_ready
  );

endmodule

/* osd_overlay_top.sv */
/*
  Top level of the OSD overlay. CPU bus in, console video in, video with
  the bitmap window laid over it out, two clocks later.
*/
`timescale 1ns/1ns

module osd_overlay_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_cpu_valid,
  input  osd_bus_pkg::cpu_req_t  i_cpu_req,
  output logic                   o_cpu_ready,
  output osd_bus_pkg::bus_word_t o_cpu_rdata,
  input  osd_video_pkg::video_t  i_video,
  output osd_video_pkg::video_t  o_video
);

  import osd_bus_pkg::*;
  import osd_video_pkg::*;

  logic      ram_req;
  ram_addr_t ram_addr;
  bus_word_t ram_wdata;
  bus_strb_t ram_wstrb;
  logic      cpu_grant;
  bus_word_t ram_rdata;
  logic      osd_enable;
  logic      fetch;
  ram_addr_t fetch_addr;
  pix_info   pix;

  //////////////////////////////////////////////////////////////////////
  // input side

  osd_bus_port u_bus_port (
    .clk          (clk),
    .rst          (rst),
    .i_cpu_valid  (i_cpu_valid),
    .i_cpu_req    (i_cpu_req),
    .o_cpu_ready  (o_cpu_ready),
    .o_cpu_rdata  (o_cpu_rdata),
    .o_ram_req    (ram_req),
    .o_ram_addr   (ram_addr),
    .o_ram_wdata  (ram_wdata),
    .o_ram_wstrb  (ram_wstrb),
    .i_cpu_grant  (cpu_grant),
    .i_ram_rdata  (ram_rdata),
    .o_osd_enable (osd_enable)
  );

  // processing
  osd_raster u_raster (
    .clk          (clk),
    .rst          (rst),
    .i_video      (i_video),
    .i_osd_enable (osd_enable),
    .o_fetch      (fetch),
    .o_fetch_addr (fetch_addr),
    .o_pix        (pix)
  );

  osd_ram u_ram (
    .clk          (clk),
    .i_fetch      (fetch),
    .i_fetch_addr (fetch_addr),
    .i_cpu_req    (ram_req),
    .i_cpu_addr   (ram_addr),
    .i_cpu_wdata  (ram_wdata),
    .i_cpu_wstrb  (ram_wstrb),
    .o_cpu_grant  (cpu_grant),
    .o_rdata      (ram_rdata)
  );

  // output side
  osd_pixel_out u_pixel_out (
    .clk     (clk),
    .rst     (rst),
    .i_pix   (pix),
    .i_rdata (ram_rdata),
    .o_video (o_video)
  );

endmodule

/* osd_pixel_out.sv */
/*
  Output stage of the overlay. Picks the bitmap byte for the current
  8-pixel group, selects the pixel bit and mixes the overlay colors over
  the console picture. Output is registered.
*/
`timescale 1ns/1ns

module osd_pixel_out (
  input  logic                   clk,
  input  logic                   rst,
  input  osd_video_pkg::pix_info i_pix,
  input  osd_bus_pkg::bus_word_t i_rdata,
  output osd_video_pkg::video_t  o_video
);

  import osd_video_pkg::*;

  logic [7:0] lane_byte;
  logic [7:0] cur_byte;
  logic [7:0] byte_q;
  logic       pix_bit;
  rgb_t       mix_rgb;

  // byte of the fetched word for this group
  always_comb begin
    case (i_pix.lane)
      2'd0:    lane_byte = i_rdata[7:0];
      2'd1:    lane_byte = i_rdata[15:8];
      2'd2:    lane_byte = i_rdata[23:16];
      default: lane_byte = i_rdata[31:24];
    endcase
  end

  // fetch pixel uses the fresh word, the other seven the saved byte
  assign cur_byte = i_pix.fetch ? lane_byte : byte_q;
  assign pix_bit  = cur_byte[i_pix.bit_idx];

  always_ff @(posedge clk) begin
    if (i_pix.fetch) begin
      byte_q <= lane_byte;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // color mix

  always_comb begin
    if (!i_pix.video.de) begin
      mix_rgb = '0;
    end else if (i_pix.in_win) begin
      mix_rgb = pix_bit ? FG_RGB : BG_RGB;
    end else begin
      mix_rgb = i_pix.video.rgb;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_video <= '0;
    end else begin
      o_video.de  <= i_pix.video.de;
      o_video.hs  <= i_pix.video.hs;
      o_video.vs  <= i_pix.video.vs;
      o_video.rgb <= mix_rgb;
    end
  end

endmodule

/* osd_ram.sv */
/*
  Bitmap RAM shared by the video fetch and the CPU. Four byte lanes,
  one port, video first; a CPU request is granted in any free cycle.
  Every access returns the addressed word one cycle later.
*/
`timescale 1ns/1ns

module osd_ram (
  input  logic                   clk,
  input  logic                   i_fetch,
  input  osd_bus_pkg::ram_addr_t i_fetch_addr,
  input  logic                   i_cpu_req,
  input  osd_bus_pkg::ram_addr_t i_cpu_addr,
  input  osd_bus_pkg::bus_word_t i_cpu_wdata,
  input  osd_bus_pkg::bus_strb_t i_cpu_wstrb,
  output logic                   o_cpu_grant,
  output osd_bus_pkg::bus_word_t o_rdata
);

  import osd_bus_pkg::*;

  ram_addr_t addr;
  logic      access;

  // video fetch owns the port when present
  assign o_cpu_grant = i_cpu_req && !i_fetch;
  assign addr        = i_fetch ? i_fetch_addr : i_cpu_addr;
  assign access      = i_fetch || o_cpu_grant;

  // lane 0 holds bits 7..0
  for (genvar l = 0; l < 4; l++) begin : g_lane
    logic [7:0] mem [RAM_WORDS];
    logic [7:0] rd_q;

    always_ff @(posedge clk) begin
      if (o_cpu_grant && i_cpu_wstrb[l]) begin
        mem[addr] <= i_cpu_wdata[l*8 +: 8];
      end
      if (access) begin
        rd_q <= mem[addr];
      end
    end

    assign o_rdata[l*8 +: 8] = rd_q;
  end

  // fetches never come back to back
  // so a waiting CPU request gets the port the next cycle
  a_fetch_spacing: assert property (
    @(posedge clk) i_fetch |=> !i_fetch
  );

endmodule

/* osd_raster.sv */
/*
  Follows the incoming video to find the current pixel position and
  issues bitmap word fetches for the overlay window. The video and the
  per-pixel window info leave here one register stage later.
*/
`timescale 1ns/1ns

module osd_raster (
  input  logic                   clk,
  input  logic                   rst,
  input  osd_video_pkg::video_t  i_video,
  input  logic                   i_osd_enable,
  output logic                   o_fetch,
  output osd_bus_pkg::ram_addr_t o_fetch_addr,
  output osd_video_pkg::pix_info o_pix
);

  import osd_video_pkg::*;
  import osd_bus_pkg::*;

  coord_t x_q;
  coord_t y_q;
  logic   in_win;

  // x counts active pixels, y counts lines that had any
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else begin
      if (i_video.hs) begin
        x_q <= '0;
      end else if (i_video.de) begin
        x_q <= x_q + 1'b1;
      end
      if (i_video.vs) begin
        y_q <= '0;
      end else if (i_video.hs && x_q != '0) begin
        y_q <= y_q + 1'b1;
      end
    end
  end

  assign in_win = i_osd_enable && i_video.de &&
                  x_q < coord_t'(WIN_W) && y_q < coord_t'(WIN_H);

  // first pixel of each 8-pixel group
  assign o_fetch      = in_win && x_q[2:0] == 3'd0;
  assign o_fetch_addr = ram_addr_t'(y_q) * ram_addr_t'(WORDS_PER_ROW) +
                        ram_addr_t'(x_q >> 5);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_pix <= '0;
    end else begin
      o_pix.video   <= i_video;
      o_pix.in_win  <= in_win;
      o_pix.fetch   <= o_fetch;
      o_pix.lane    <= x_q[4:3];
      // msb is the leftmost pixel
      o_pix.bit_idx <= 3'd7 - x_q[2:0];
    end
  end

endmodule

/* osd_video_pkg.sv */
/*
  Video side definitions for the OSD overlay: pixel stream struct,
  window geometry, overlay colors and the raster-to-output stage record.
*/
package osd_video_pkg;

  // red in the high byte
  typedef logic [23:0] rgb_t;
  typedef logic [8:0]  coord_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
    rgb_t rgb;
  } video_t;

  //////////////////////////////////////////////////////////////////////
  // window, one bit per pixel, top-left corner

  localparam int WIN_W         = 256;
  localparam int WIN_H         = 64;
  localparam int WORDS_PER_ROW = 8;

  localparam rgb_t FG_RGB = 24'hff_ff_ff;
  localparam rgb_t BG_RGB = 24'h30_40_50;

  // input to output, in clocks
  localparam int PIX_LATENCY = 2;

  // raster stage handed to the pixel output
  typedef struct packed {
    video_t     video;
    logic       in_win;
    logic       fetch;
    logic [1:0] lane;
    logic [2:0] bit_idx;
  } pix_info;

endpackage

/* tb_osd_overlay.sv */
/*
  Testbench for the OSD overlay top level. A free-running video source
  feeds the DUT, bus tasks drive the CPU port, and a checker compares
  every output pixel with a reference model of the overlay rules.
*/
`timescale 1ns/1ns

module tb_osd_overlay;

  import osd_bus_pkg::*;
  import osd_video_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int ACT_W      = 272;
  localparam int LINE_CYC   = 312;
  localparam int HS_START   = 280;
  localparam int HS_LEN     = 8;
  localparam int ACT_LINES  = 70;
  localparam int VS_LINES   = 4;
  localparam int FRAME_CYC  = LINE_CYC * (ACT_LINES + VS_LINES);
  localparam int N_FRAMES   = 10;
  localparam int BUS_LIMIT  = 2000;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  logic      i_cpu_valid = 1'b0;
  cpu_req_t  i_cpu_req = '0;
  logic      o_cpu_ready;
  bus_word_t o_cpu_rdata;
  video_t    i_video = '0;
  video_t    o_video;

  int        seed = 61;
  int        main_errors = 0;
  int        vid_errors = 0;
  int        tests = 0;
  int        failed = 0;
  int        checked = 0;
  int        frame_cnt = 0;
  logic      check_on = 1'b0;
  logic      ref_enable = 1'b0;
  bus_word_t model [RAM_WORDS];

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  osd_overlay_top dut (
    .clk         (clk),
    .rst         (rst),
    .i_cpu_valid (i_cpu_valid),
    .i_cpu_req   (i_cpu_req),
    .o_cpu_ready (o_cpu_ready),
    .o_cpu_rdata (o_cpu_rdata),
    .i_video     (i_video),
    .o_video     (o_video)
  );

  //////////////////////////////////////////////////////////////////////
  // video source

  task automatic drive_line(input logic active, input logic vsync);
    bus_word_t r;
    for (int i = 0; i < LINE_CYC; i++) begin
      @(posedge clk);
      #1;
      r = $random(seed);
      i_video.de  = active && i < ACT_W;
      i_video.hs  = i >= HS_START && i < HS_START + HS_LEN;
      i_video.vs  = vsync;
      i_video.rgb = i_video.de ? r[23:0] : '0;
    end
  endtask

  // vs lines first, then the active lines
  initial begin
    wait (!rst);
    forever begin
      frame_cnt++;
      for (int l = 0; l < VS_LINES; l++) begin
        drive_line(1'b0, 1'b1);
      end
      for (int l = 0; l < ACT_LINES; l++) begin
        drive_line(1'b1, 1'b0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference and checker

  function automatic video_t expected_pixel(video_t v, logic en, int px, int py);
    video_t     r;
    ram_addr_t  w;
    logic [7:0] b;
    logic [2:0] bi;
    r  = v;
    w  = ram_addr_t'(py * WORDS_PER_ROW + px / 32);
    b  = 8'(model[w] >> (8 * ((px / 8) % 4)));
    bi = 3'(7 - px % 8);
    if (!v.de) begin
      r.rgb = '0;
    end else if (en && px < WIN_W && py < WIN_H) begin
      r.rgb = b[bi] ? FG_RGB : BG_RGB;
    end
    return r;
  endfunction

  int     ref_x = 0;
  int     ref_y = 0;
  video_t exp_q [PIX_LATENCY] = '{default: '0};
  logic   vld_q [PIX_LATENCY] = '{default: 1'b0};

  // input sampled at one negedge is due PIX_LATENCY negedges later
  always @(negedge clk) begin
    if (vld_q[PIX_LATENCY-1]) begin
      checked++;
      if (o_video !== exp_q[PIX_LATENCY-1]) begin
        vid_errors++;
        $display("Mismatch o_video at %0t: expected %h got %h", $time,
                 exp_q[PIX_LATENCY-1], o_video);
      end
    end
    for (int i = PIX_LATENCY - 1; i > 0; i--) begin
      exp_q[i] = exp_q[i-1];
      vld_q[i] = vld_q[i-1];
    end
    exp_q[0] = expected_pixel(i_video, ref_enable, ref_x, ref_y);
    vld_q[0] = check_on && !rst;
    // y first, it looks at the old x
    if (rst) begin
      ref_x = 0;
      ref_y = 0;
    end else begin
      if (i_video.vs) begin
        ref_y = 0;
      end else if (i_video.hs && ref_x != 0) begin
        ref_y++;
      end
      if (i_video.hs) begin
        ref_x = 0;
      end else if (i_video.de) begin
        ref_x++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus tasks

  task automatic bus_access(input bus_addr_t addr, input bus_word_t wdata,
                            input bus_strb_t strb, output bus_word_t rdata);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    i_cpu_valid     = 1'b1;
    i_cpu_req.addr  = addr;
    i_cpu_req.wdata = wdata;
    i_cpu_req.wstrb = strb;
    @(negedge clk);
    while (!o_cpu_ready && n < BUS_LIMIT) begin
      n++;
      @(negedge clk);
    end
    rdata = o_cpu_rdata;
    if (!o_cpu_ready) begin
      main_errors++;
      $display("Bus access to %h got no ready within %0d cycles", addr, BUS_LIMIT);
    end
    @(posedge clk);
    #1;
    i_cpu_valid = 1'b0;
  endtask

  function automatic bus_word_t merge_word(bus_word_t old, bus_word_t nw, bus_strb_t strb);
    bus_word_t r;
    for (int l = 0; l < 4; l++) begin
      r[l*8 +: 8] = strb[l] ? nw[l*8 +: 8] : old[l*8 +: 8];
    end
    return r;
  endfunction

  function automatic bus_addr_t ram_byte_addr(int idx);
    return {RAM_REGION, 16'h0000, ram_addr_t'(idx), 2'b00};
  endfunction

  task automatic write_word(input bus_addr_t addr, input bus_word_t data, input bus_strb_t strb);
    bus_word_t ignored;
    bus_access(addr, data, strb, ignored);
    if (addr[31:28] == RAM_REGION) begin
      model[addr[11:2]] = merge_word(model[addr[11:2]], data, strb);
    end
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_word_t exp);
    bus_word_t got;
    bus_access(addr, '0, '0, got);
    if (got !== exp) begin
      main_errors++;
      $display("Mismatch o_cpu_rdata at %h: expected %h got %h", addr, exp, got);
    end
  endtask

  // compare exactly one frame, boundary to boundary
  task automatic check_frame();
    int f0;
    int c0;
    f0 = frame_cnt;
    wait (frame_cnt != f0);
    c0 = checked;
    check_on = 1'b1;
    f0 = frame_cnt;
    wait (frame_cnt != f0);
    check_on = 1'b0;
    repeat (PIX_LATENCY + 1) @(negedge clk);
    if (checked - c0 != FRAME_CYC) begin
      main_errors++;
      $display("Video check covered %0d pixels instead of %0d", checked - c0, FRAME_CYC);
    end
  endtask

  task automatic end_test(input string name, input int err0);
    int e;
    e = main_errors + vid_errors - err0;
    tests++;
    if (e != 0) begin
      failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests, name, e == 0 ? "ok" : "FAILED", e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int        err0;
    bus_word_t w;
    err0 = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (o_cpu_ready !== 1'b0) begin
      main_errors++;
      $display("Mismatch o_cpu_ready: expected 0 got %h", o_cpu_ready);
    end
    if (o_video !== '0) begin
      main_errors++;
      $display("Mismatch o_video: expected %h got %h", 27'h0, o_video);
    end
    end_test("reset state", err0);

    err0 = main_errors + vid_errors;
    write_word(CTRL_ADDR, 32'hffff_ffff, 4'hf);
    read_check(CTRL_ADDR, 32'h0000_0001);
    write_word(CTRL_ADDR, 32'h0000_0000, 4'hf);
    read_check(CTRL_ADDR, 32'h0000_0000);
    write_word(32'h2000_0010, 32'hdead_beef, 4'hf);
    read_check(32'h2000_0010, 32'h0000_0000);
    // unmapped write leaves the control bit alone
    read_check(CTRL_ADDR, 32'h0000_0000);
    end_test("control and unmapped", err0);

    err0 = main_errors + vid_errors;
    for (int k = 700; k < 702; k++) begin
      write_word(ram_byte_addr(k), 32'h1122_3344, 4'hf);
      read_check(ram_byte_addr(k), model[k]);
      write_word(ram_byte_addr(k), 32'haabb_ccdd, 4'b0001 << (k - 700));
      write_word(ram_byte_addr(k), 32'h5566_7788, 4'b0100 << (k - 700));
      read_check(ram_byte_addr(k), model[k]);
    end
    end_test("ram strobe merge", err0);

    err0 = main_errors + vid_errors;
    ref_enable = 1'b0;
    check_frame();
    end_test("overlay disabled", err0);

    // random bitmap over the whole window
    err0 = main_errors + vid_errors;
    for (int i = 0; i < WIN_H * WORDS_PER_ROW; i++) begin
      w = $random(seed);
      write_word(ram_byte_addr(i), w, 4'hf);
    end
    write_word(CTRL_ADDR, 32'h0000_0001, 4'h1);
    ref_enable = 1'b1;
    check_frame();
    end_test("overlay enabled frame", err0);

    // first active line sits inside the window, so fetches compete
    // the first access is raised on the fetch pixel x = 8 and must wait
    err0 = main_errors + vid_errors;
    @(negedge clk);
    while (!i_video.de) begin
      @(negedge clk);
    end
    repeat (7) @(negedge clk);
    write_word(ram_byte_addr(9), 32'hf0f0_0ff0, 4'hf);
    write_word(ram_byte_addr(9), 32'h0000_aa00, 4'b0010);
    read_check(ram_byte_addr(9), model[9]);
    read_check(ram_byte_addr(300), model[300]);
    read_check(CTRL_ADDR, 32'h0000_0001);
    check_frame();
    end_test("bus during active video", err0);

    $display("tests %0d, failed %0d, pixels checked %0d, errors %0d",
             tests, failed, checked, main_errors + vid_errors);
    if (failed == 0 && main_errors + vid_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(N_FRAMES * FRAME_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d frames, the run did not finish", N_FRAMES);
    $display("Verification failed");
    $finish;
  end

endmodule
